//--- logic/sha3_cfg_pkg.sv
/*
  SHA-3 function configuration for Keccak-f[1600] with 64-bit words.
  Only SHA3 and SHAKE are offered and cSHAKE is not supported.
  Unused strength encodings fall back to the smallest rate.
*/
package sha3_cfg_pkg;

  // Message word and state geometry
  parameter int MsgWidth   = 64;
  parameter int MsgStrbW   = MsgWidth / 8;
  parameter int StateWords = 25;
  // Counter reaches the largest rate (21), so 5 bits suffice
  parameter int WordCntW   = 5;

  typedef enum logic [1:0] {
    Sha3  = 2'b00,
    Shake = 2'b10
  } sha3_mode_e;

  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } keccak_strength_e;

  // Rate in 64-bit words, (1600 - 2*strength) / 64
  function automatic logic [WordCntW-1:0] rate_words(keccak_strength_e strength);
    case (strength)
      L128:    return WordCntW'(21);
      L224:    return WordCntW'(18);
      L256:    return WordCntW'(17);
      L384:    return WordCntW'(13);
      L512:    return WordCntW'(9);
      default: return WordCntW'(9);
    endcase
  endfunction

  // Domain bits plus the first pad10*1 bit, LSB first
  function automatic logic [7:0] suffix_byte(sha3_mode_e mode);
    return (mode == Shake) ? 8'h1F : 8'h06;
  endfunction

endpackage

//--- logic/sha3_pad_pkg.sv
/*
  Internal types of the padding unit.
  Beat layout matches the 64-bit message word with one strobe per byte.
*/
package sha3_pad_pkg;

  // Absorb sequencer states
  typedef enum logic [2:0] {
    StIdle    = 3'd0,
    StMessage = 3'd1,
    StPad     = 3'd2,
    StPadRun  = 3'd3,
    StPadZero = 3'd4,
    StFlush   = 3'd5
  } pad_st_e;

  // Source of the word written into the block buffer
  typedef enum logic [1:0] {
    SrcNone    = 2'd0,
    SrcMsg     = 2'd1,
    SrcSuffix  = 2'd2,
    SrcZeroEnd = 2'd3
  } word_src_e;

  // One message beat, strobes contiguous from byte 0
  typedef struct packed {
    logic [sha3_cfg_pkg::MsgWidth-1:0] data;
    logic [sha3_cfg_pkg::MsgStrbW-1:0] strb;
  } msg_beat_t;

  // Block buffer command, write and clear are exclusive
  typedef struct packed {
    logic write;
    logic clear;
  } buf_cmd_t;

endpackage

//--- logic/pad_fsm.sv
`timescale 1ns/1ps

/*
  Absorb sequencer of the padding unit.
  start_i and process_i are single-cycle pulses and never coincide.
  Between message blocks only keccak_ready_i back-pressures, and
  completion is awaited after the final padded block only.
*/
module pad_fsm (
  input  logic                    clk_i,
  input  logic                    rst_b,
  input  logic                    start_i,
  input  logic                    process_i,
  input  logic                    msg_valid_i,
  input  logic                    msg_partial_i,
  input  logic                    keccak_ready_i,
  input  logic                    keccak_complete_i,
  input  logic                    block_full_i,
  input  logic                    last_word_i,
  output logic                    msg_ready_o,
  output logic                    keccak_run_o,
  output logic                    absorbed_o,
  output sha3_pad_pkg::word_src_e src_sel_o,
  output logic                    latch_en_o,
  output logic                    latch_clr_o,
  output sha3_pad_pkg::buf_cmd_t  buf_cmd_o
);

  sha3_pad_pkg::pad_st_e st_q;
  sha3_pad_pkg::pad_st_e st_d;
  logic                  process_q;
  logic                  go_pad;
  logic                  absorbed_d;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  // Process request may arrive while a full block waits for Keccak
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      process_q <= 1'b0;
    end else if (start_i || go_pad) begin
      process_q <= 1'b0;
    end else if (process_i) begin
      process_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st_q       <= sha3_pad_pkg::StIdle;
      absorbed_o <= 1'b0;
    end else begin
      st_q       <= st_d;
      absorbed_o <= absorbed_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    st_d         = st_q;
    msg_ready_o  = 1'b0;
    keccak_run_o = 1'b0;
    src_sel_o    = sha3_pad_pkg::SrcNone;
    latch_en_o   = 1'b0;
    latch_clr_o  = 1'b0;
    buf_cmd_o    = '0;
    go_pad       = 1'b0;
    absorbed_d   = 1'b0;

    case (st_q)
      sha3_pad_pkg::StIdle: begin
        if (start_i) begin
          st_d = sha3_pad_pkg::StMessage;
        end
      end

      sha3_pad_pkg::StMessage: begin
        src_sel_o = sha3_pad_pkg::SrcMsg;
        if (block_full_i) begin
          // Block boundary has priority, hold the stream meanwhile
          if (keccak_ready_i) begin
            keccak_run_o    = 1'b1;
            buf_cmd_o.clear = 1'b1;
          end
        end else if (process_q || process_i) begin
          go_pad = 1'b1;
          st_d   = sha3_pad_pkg::StPad;
        end else if (msg_valid_i) begin
          msg_ready_o = 1'b1;
          // Partial tail goes to the latch, full words to the buffer
          if (msg_partial_i) begin
            latch_en_o = 1'b1;
          end else begin
            buf_cmd_o.write = 1'b1;
          end
        end
      end

      sha3_pad_pkg::StPad: begin
        // Suffix word merges the latched tail, latch is done afterwards
        src_sel_o       = sha3_pad_pkg::SrcSuffix;
        buf_cmd_o.write = 1'b1;
        latch_clr_o     = 1'b1;
        if (last_word_i) begin
          st_d = sha3_pad_pkg::StPadRun;
        end else begin
          st_d = sha3_pad_pkg::StPadZero;
        end
      end

      sha3_pad_pkg::StPadRun: begin
        // Suffix already carried the end bit
        if (keccak_ready_i) begin
          keccak_run_o    = 1'b1;
          buf_cmd_o.clear = 1'b1;
          st_d            = sha3_pad_pkg::StFlush;
        end
      end

      sha3_pad_pkg::StPadZero: begin
        src_sel_o = sha3_pad_pkg::SrcZeroEnd;
        if (block_full_i) begin
          if (keccak_ready_i) begin
            keccak_run_o    = 1'b1;
            buf_cmd_o.clear = 1'b1;
            st_d            = sha3_pad_pkg::StFlush;
          end
        end else begin
          // Zero words up to the end-bit word
          buf_cmd_o.write = 1'b1;
        end
      end

      sha3_pad_pkg::StFlush: begin
        if (keccak_complete_i) begin
          absorbed_d = 1'b1;
          st_d       = sha3_pad_pkg::StIdle;
        end
      end

      default: begin
        st_d = sha3_pad_pkg::StIdle;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Run clears the block, so a second run needs a refill first
  a_run_pulse: assert property (@(posedge clk_i) disable iff (!rst_b)
    keccak_run_o |=> !keccak_run_o);

  a_cmd_excl: assert property (@(posedge clk_i) disable iff (!rst_b)
    !(buf_cmd_o.write && buf_cmd_o.clear));

endmodule

//--- logic/pad_word_gen.sv
`timescale 1ns/1ps

/*
  Builds the word written into the block buffer.
  Only one partial beat per message, at its end, is expected.
  Suffix merging is tied to 64-bit words.
*/
module pad_word_gen (
  input  logic                              clk_i,
  input  logic                              rst_b,
  input  sha3_pad_pkg::msg_beat_t           msg_i,
  input  sha3_cfg_pkg::sha3_mode_e          mode_i,
  input  sha3_pad_pkg::word_src_e           src_sel_i,
  input  logic                              latch_en_i,
  input  logic                              latch_clr_i,
  input  logic                              last_word_i,
  output logic                              msg_partial_o,
  output logic [sha3_cfg_pkg::MsgWidth-1:0] wr_word_o
);

  localparam int MsgBytes = sha3_cfg_pkg::MsgStrbW;

  // Partial word never fills the top byte, so it is not kept
  logic [sha3_cfg_pkg::MsgWidth-9:0] part_data_q;
  logic [MsgBytes-2:0]               part_strb_q;
  logic [sha3_cfg_pkg::MsgWidth-1:0] data_ext;
  logic [MsgBytes-1:0]               strb_ext;
  logic [MsgBytes-1:0]               prev_ext;
  logic [7:0]                        suffix;
  logic [sha3_cfg_pkg::MsgWidth-1:0] pad_word;

  assign msg_partial_o = ~&msg_i.strb;

  //////////////////////////////////////////////////////////////////////
  // Partial-word latch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      part_strb_q <= '0;
    end else if (latch_en_i) begin
      part_strb_q <= msg_i.strb[MsgBytes-2:0];
    end else if (latch_clr_i) begin
      part_strb_q <= '0;
    end
  end

  // Data bytes only count where the strobe is set
  always_ff @(posedge clk_i) begin
    if (latch_en_i) begin
      part_data_q <= msg_i.data[sha3_cfg_pkg::MsgWidth-9:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Suffix merge
  //////////////////////////////////////////////////////////////////////

  assign data_ext = {8'h00, part_data_q};
  assign strb_ext = {1'b0, part_strb_q};
  // Strobe of the byte below, byte 0 sees a set one
  assign prev_ext = {strb_ext[MsgBytes-2:0], 1'b1};
  assign suffix   = sha3_cfg_pkg::suffix_byte(mode_i);

  always_comb begin
    pad_word = '0;
    for (int i = 0; i < MsgBytes; i++) begin
      if (strb_ext[i]) begin
        pad_word[8*i +: 8] = data_ext[8*i +: 8];
      end else if (prev_ext[i]) begin
        // First free byte takes the suffix
        pad_word[8*i +: 8] = suffix;
      end
    end
    // pad10*1 end bit, may share byte 7 with the suffix (0x86)
    pad_word[sha3_cfg_pkg::MsgWidth-1] = pad_word[sha3_cfg_pkg::MsgWidth-1] | last_word_i;
  end

  // Word source mux
  always_comb begin
    case (src_sel_i)
      sha3_pad_pkg::SrcMsg:     wr_word_o = msg_i.data;
      sha3_pad_pkg::SrcSuffix:  wr_word_o = pad_word;
      sha3_pad_pkg::SrcZeroEnd: wr_word_o = {last_word_i, {(sha3_cfg_pkg::MsgWidth-1){1'b0}}};
      default:                  wr_word_o = '0;
    endcase
  end

  // Latch request from the sequencer only on a genuine tail beat
  a_partial_strb: assert property (@(posedge clk_i) disable iff (!rst_b)
    latch_en_i |-> (msg_i.strb != '1) && (((msg_i.strb + 1'b1) & msg_i.strb) == '0));

endmodule

//--- logic/block_buffer.sv
`timescale 1ns/1ps

/*
  25-word block register feeding Keccak-f[1600].
  Words are written in order from address 0 and the counter never wraps.
  strength_i must stay stable while a message is absorbed.
*/
module block_buffer (
  input  logic                                   clk_i,
  input  logic                                   rst_b,
  input  sha3_cfg_pkg::keccak_strength_e         strength_i,
  input  sha3_pad_pkg::buf_cmd_t                 buf_cmd_i,
  input  logic [sha3_cfg_pkg::MsgWidth-1:0]      wr_word_i,
  output logic [sha3_cfg_pkg::StateWords*sha3_cfg_pkg::MsgWidth-1:0] keccak_data_o,
  output logic                                   block_full_o,
  output logic                                   last_word_o
);

  logic [sha3_cfg_pkg::StateWords-1:0][sha3_cfg_pkg::MsgWidth-1:0] buf_q;
  logic [sha3_cfg_pkg::WordCntW-1:0]                               cnt_q;
  logic [sha3_cfg_pkg::WordCntW-1:0]                               rate;

  assign rate = sha3_cfg_pkg::rate_words(strength_i);

  //////////////////////////////////////////////////////////////////////
  // Word counter and storage
  //////////////////////////////////////////////////////////////////////

  // Counter doubles as the write address
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q <= '0;
    end else if (buf_cmd_i.clear) begin
      cnt_q <= '0;
    end else if (buf_cmd_i.write) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Capacity words stay zero, rate words zero-filled between blocks
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      buf_q <= '0;
    end else if (buf_cmd_i.clear) begin
      buf_q <= '0;
    end else if (buf_cmd_i.write) begin
      buf_q[cnt_q] <= wr_word_i;
    end
  end

  assign keccak_data_o = buf_q;

  // Position flags
  assign block_full_o = (cnt_q == rate);
  assign last_word_o  = (cnt_q == rate - 1'b1);

  // Sequencer must stop writing once the rate is reached
  a_wr_in_rate: assert property (@(posedge clk_i) disable iff (!rst_b)
    buf_cmd_i.write |-> (cnt_q < rate));

endmodule

//--- logic/sha3_pad_top.sv
`timescale 1ns/1ps

/*
  SHA-3 padding unit, absorbing side, SHA3 and SHAKE only.
  mode_i and strength_i must be stable from start_i to absorbed_o.
  keccak_data_o is valid during the keccak_run_o cycle only.
*/
module sha3_pad_top (
  input  logic                                   clk_i,
  input  logic                                   rst_b,
  // Message stream
  input  logic                                   msg_valid_i,
  input  sha3_pad_pkg::msg_beat_t                msg_i,
  output logic                                   msg_ready_o,
  // Control pulses
  input  logic                                   start_i,
  input  logic                                   process_i,
  input  sha3_cfg_pkg::sha3_mode_e               mode_i,
  input  sha3_cfg_pkg::keccak_strength_e         strength_i,
  // Keccak round side
  output logic [sha3_cfg_pkg::StateWords*sha3_cfg_pkg::MsgWidth-1:0] keccak_data_o,
  input  logic                                   keccak_ready_i,
  output logic                                   keccak_run_o,
  input  logic                                   keccak_complete_i,
  output logic                                   absorbed_o
);

  sha3_pad_pkg::word_src_e           src_sel;
  sha3_pad_pkg::buf_cmd_t            buf_cmd;
  logic                              latch_en;
  logic                              latch_clr;
  logic                              msg_partial;
  logic                              block_full;
  logic                              last_word;
  logic [sha3_cfg_pkg::MsgWidth-1:0] wr_word;

  // Sequencer
  pad_fsm u_pad_fsm (
    .clk_i             (clk_i),
    .rst_b             (rst_b),
    .start_i           (start_i),
    .process_i         (process_i),
    .msg_valid_i       (msg_valid_i),
    .msg_partial_i     (msg_partial),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_complete_i (keccak_complete_i),
    .block_full_i      (block_full),
    .last_word_i       (last_word),
    .msg_ready_o       (msg_ready_o),
    .keccak_run_o      (keccak_run_o),
    .absorbed_o        (absorbed_o),
    .src_sel_o         (src_sel),
    .latch_en_o        (latch_en),
    .latch_clr_o       (latch_clr),
    .buf_cmd_o         (buf_cmd)
  );

  // Word source and suffix merge
  pad_word_gen u_pad_word_gen (
    .clk_i         (clk_i),
    .rst_b         (rst_b),
    .msg_i         (msg_i),
    .mode_i        (mode_i),
    .src_sel_i     (src_sel),
    .latch_en_i    (latch_en),
    .latch_clr_i   (latch_clr),
    .last_word_i   (last_word),
    .msg_partial_o (msg_partial),
    .wr_word_o     (wr_word)
  );

  // Block storage
  block_buffer u_block_buffer (
    .clk_i         (clk_i),
    .rst_b         (rst_b),
    .strength_i    (strength_i),
    .buf_cmd_i     (buf_cmd),
    .wr_word_i     (wr_word),
    .keccak_data_o (keccak_data_o),
    .block_full_o  (block_full),
    .last_word_o   (last_word)
  );

endmodule

//--- sim/tb_sha3_pad.sv
`timescale 1ns/1ps

/*
  Testbench for the SHA-3 padding unit with a Keccak stand-in.
  Holds at most 256 message bytes and 32 expected blocks over the whole run.
  Checks run on the falling edge, while the DUT outputs are stable.
*/
module tb_sha3_pad;

  localparam int BlockBits = 1600;
  // Each message needs under 100 cycles: beats, gaps, padding words and
  // 7 cycles per Keccak run, so this limit leaves a wide margin
  localparam int MaxCycles = 20000;

  logic                           clk_i = 1'b0;
  logic                           rst_b;
  logic                           msg_valid_i;
  sha3_pad_pkg::msg_beat_t        msg_i;
  logic                           msg_ready_o;
  logic                           start_i;
  logic                           process_i;
  sha3_cfg_pkg::sha3_mode_e       mode_i;
  sha3_cfg_pkg::keccak_strength_e strength_i;
  logic [BlockBits-1:0]           keccak_data_o;
  logic                           keccak_ready_i;
  logic                           keccak_run_o;
  logic                           keccak_complete_i;
  logic                           absorbed_o;

  // Reference model and monitor state
  logic [7:0]           msg_bytes [0:255];
  logic [BlockBits-1:0] exp_blocks [0:31];
  logic [BlockBits-1:0] exp_block;
  int                   exp_count;
  int                   msg_cnt;
  int                   cur_rate_words;
  logic                 in_msg;
  logic [31:0]          lfsr_q;
  int                   run_idx = 0;
  int                   absorb_cnt = 0;
  int                   words_in_block = 0;
  int                   cycles = 0;
  int                   busy_left;
  logic                 run_seen;

  sha3_pad_top dut (.*);

  always #2 clk_i = ~clk_i;

  assign exp_block = exp_blocks[5'(run_idx)];

  //////////////////////////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////////////////////////

  task automatic stop_failed();
    $display("tests failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic report_fail(input string what);
    $display("[ERROR] t=%0t %s", $time, what);
    stop_failed();
  endtask

  task automatic report_block(input string name, input logic [BlockBits-1:0] got,
                              input logic [BlockBits-1:0] exp);
    $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    stop_failed();
  endtask

  task automatic report_count(input string name, input int got, input int exp);
    $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
    stop_failed();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Random bytes and reference padder
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic next_bit(output logic bit_o);
    bit_o  = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
  endtask

  task automatic next_byte(output logic [7:0] b);
    logic bt;
    b = '0;
    for (int k = 0; k < 8; k++) begin
      next_bit(bt);
      b = {bt, b[7:1]};
    end
  endtask

  // Message, suffix at the first free byte, zero fill, end bit in the last rate byte
  task automatic build_expected(input int len, input logic [7:0] suffix, input int rate_w);
    int                   rate_b;
    int                   nblk;
    int                   pos;
    logic [BlockBits-1:0] blk;
    rate_b = rate_w * 8;
    // The suffix always takes a byte, so a full last block adds a padding block
    nblk = len / rate_b + 1;
    for (int b = 0; b < nblk; b++) begin
      blk = '0;
      for (int k = 0; k < rate_b; k++) begin
        pos = b * rate_b + k;
        if (pos < len) begin
          blk = blk | (BlockBits'(msg_bytes[8'(pos)]) << (8 * k));
        end else if (pos == len) begin
          blk = blk | (BlockBits'(suffix) << (8 * k));
        end
      end
      if (b == nblk - 1) begin
        blk = blk | (BlockBits'(1) << (rate_b * 8 - 1));
      end
      exp_blocks[5'(exp_count)] = blk;
      exp_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Bytes above the strobes carry ones, the DUT must ignore them
  task automatic send_beat(input int w, input int len);
    int   nbytes;
    logic taken;
    nbytes     = (len - 8 * w >= 8) ? 8 : len - 8 * w;
    msg_i.data = '1;
    for (int k = 0; k < nbytes; k++) begin
      msg_i.data = (msg_i.data & ~(64'hFF << (8 * k))) |
                   (64'(msg_bytes[8'(8 * w + k)]) << (8 * k));
    end
    msg_i.strb  = 8'((1 << nbytes) - 1);
    msg_valid_i = 1'b1;
    taken       = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = msg_ready_o;
      @(posedge clk_i);
      #1;
    end
    msg_valid_i = 1'b0;
  endtask

  task automatic run_message(input sha3_cfg_pkg::sha3_mode_e mode,
                             input sha3_cfg_pkg::keccak_strength_e strength,
                             input int rate_w, input int len);
    logic [7:0] b;
    logic       gap;
    for (int i = 0; i < len; i++) begin
      next_byte(b);
      msg_bytes[8'(i)] = b;
    end
    build_expected(len, (mode == sha3_cfg_pkg::Shake) ? 8'h1F : 8'h06, rate_w);
    mode_i         = mode;
    strength_i     = strength;
    cur_rate_words = rate_w;
    start_i        = 1'b1;
    in_msg         = 1'b1;
    msg_cnt++;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;
    for (int w = 0; w < (len + 7) / 8; w++) begin
      send_beat(w, len);
      // Random idle cycle between beats
      // No idle cycle after a beat that fills the block
      next_bit(gap);
      if (gap && ((w + 1) % rate_w != 0)) begin
        @(posedge clk_i);
        #1;
      end
    end
    // Last beat stays valid after process_i and must never be taken
    msg_valid_i = 1'b1;
    process_i   = 1'b1;
    in_msg      = 1'b0;
    @(posedge clk_i);
    #1;
    process_i = 1'b0;
    while (absorb_cnt != msg_cnt) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    msg_valid_i = 1'b0;
  endtask

  initial begin
    lfsr_q         = 32'hee58b54c;
    rst_b          = 1'b0;
    msg_valid_i    = 1'b0;
    msg_i          = '0;
    start_i        = 1'b0;
    process_i      = 1'b0;
    mode_i         = sha3_cfg_pkg::Sha3;
    strength_i     = sha3_cfg_pkg::L256;
    exp_count      = 0;
    msg_cnt        = 0;
    cur_rate_words = 17;
    in_msg         = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_b = 1'b1;
    @(posedge clk_i);
    #1;
    // Short SHA3-256, SHAKE128 over two blocks, 0x86 tail, padding-only block
    run_message(sha3_cfg_pkg::Sha3, sha3_cfg_pkg::L256, 17, 20);
    run_message(sha3_cfg_pkg::Shake, sha3_cfg_pkg::L128, 21, 200);
    run_message(sha3_cfg_pkg::Sha3, sha3_cfg_pkg::L512, 9, 71);
    run_message(sha3_cfg_pkg::Sha3, sha3_cfg_pkg::L256, 17, 136);
    // Room for a stray late pulse
    repeat (20) @(posedge clk_i);
    if (absorb_cnt == msg_cnt && run_idx == exp_count) begin
      $display("all tests passed");
      $finish;
    end else begin
      report_fail("message, absorbed or run count differs at the end");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Keccak stand-in and monitors
  //////////////////////////////////////////////////////////////////////

  // Busy for 6 cycles after a run, completion on the 6th
  initial begin
    keccak_ready_i    = 1'b1;
    keccak_complete_i = 1'b0;
    busy_left         = 0;
    forever begin
      @(negedge clk_i);
      run_seen = keccak_run_o;
      @(posedge clk_i);
      #1;
      if (run_seen) begin
        busy_left = 6;
      end else if (busy_left > 0) begin
        busy_left = busy_left - 1;
      end
      keccak_ready_i    = (busy_left == 0);
      keccak_complete_i = (busy_left == 1);
    end
  end

  always @(negedge clk_i) begin
    if (keccak_run_o) begin
      run_idx        <= run_idx + 1;
      words_in_block <= 0;
    end else if (msg_valid_i && msg_ready_o && msg_i.strb == 8'hFF) begin
      words_in_block <= words_in_block + 1;
    end
    if (absorbed_o) begin
      absorb_cnt <= absorb_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      report_fail("timeout waiting for the DUT");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_reset_quiet: assert property (@(negedge clk_i)
    !rst_b |-> !msg_ready_o && !keccak_run_o && !absorbed_o && keccak_data_o == '0)
    else report_fail("control output or block buffer not clear during reset");

  a_block_data: assert property (@(negedge clk_i) disable iff (!rst_b)
    keccak_run_o |-> keccak_data_o == exp_block)
    else report_block("keccak_data_o", $sampled(keccak_data_o), $sampled(exp_block));

  a_run_expected: assert property (@(negedge clk_i) disable iff (!rst_b)
    keccak_run_o |-> run_idx < exp_count)
    else report_fail("keccak_run_o pulsed with no block expected");

  // No acceptance outside a message or while the block waits for Keccak
  a_ready_window: assert property (@(negedge clk_i) disable iff (!rst_b)
    msg_ready_o |-> in_msg && words_in_block < cur_rate_words)
    else report_fail("msg_ready_o high outside a message or with a full block");

  a_absorb_once: assert property (@(negedge clk_i) disable iff (!rst_b)
    absorbed_o |-> absorb_cnt < msg_cnt)
    else report_fail("absorbed_o pulsed more than once for a message");

  a_absorb_last: assert property (@(negedge clk_i) disable iff (!rst_b)
    absorbed_o |-> run_idx == exp_count)
    else report_count("runs before absorbed_o", $sampled(run_idx), $sampled(exp_count));

  a_absorb_after_done: assert property (@(negedge clk_i) disable iff (!rst_b)
    absorbed_o |-> $past(keccak_complete_i))
    else report_fail("absorbed_o without keccak_complete_i in the cycle before");

endmodule

//--- sha3_pad.f
logic/sha3_cfg_pkg.sv
logic/sha3_pad_pkg.sv
logic/pad_fsm.sv
logic/pad_word_gen.sv
logic/block_buffer.sv
logic/sha3_pad_top.sv
sim/tb_sha3_pad.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SHA-3 padding testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --top-module tb_sha3_pad \
  -Mdir "$BUILD_DIR" -o tb_sha3_pad -f sha3_pad.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sha3_pad" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL: pass line not found in $LOG"
exit 1
